// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	typedef logic [1:0] reg_idx_t;

	localparam logic [3:0] OP_BNE = 4'd0;
	localparam logic [3:0] OP_BEQ = 4'd1;
	localparam logic [3:0] OP_BGZ = 4'd2;
	localparam logic [3:0] OP_BLZ = 4'd3;
	localparam logic [3:0] OP_ADI = 4'd4;
	localparam logic [3:0] OP_ORI = 4'd5;
	localparam logic [3:0] OP_LHI = 4'd6;
	localparam logic [3:0] OP_LWD = 4'd7;
	localparam logic [3:0] OP_SWD = 4'd8;
	localparam logic [3:0] OP_JMP = 4'd9;
	localparam logic [3:0] OP_JAL = 4'd10;
	localparam logic [3:0] OP_R   = 4'd15; // Register format, operation in func

	localparam logic [5:0] FN_ADD = 6'd0;
	localparam logic [5:0] FN_SUB = 6'd1;
	localparam logic [5:0] FN_AND = 6'd2;
	localparam logic [5:0] FN_ORR = 6'd3;
	localparam logic [5:0] FN_NOT = 6'd4;
	localparam logic [5:0] FN_TCP = 6'd5;
	localparam logic [5:0] FN_SHL = 6'd6;
	localparam logic [5:0] FN_SHR = 6'd7;
	localparam logic [5:0] FN_JPR = 6'd25;
	localparam logic [5:0] FN_JRL = 6'd26;
	localparam logic [5:0] FN_WWD = 6'd28;
	localparam logic [5:0] FN_HLT = 6'd29;

	localparam reg_idx_t LINK_REG = 2'd2; // Return address of JAL and JRL

	typedef struct packed {
		logic [3:0] opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [5:0] func;
	} r_fmt_t;

	typedef struct packed {
		logic [3:0] opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		logic [7:0] imm;
	} i_fmt_t;

	// Both views cover the same 16 bits, only the low byte is read differently
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} inst_word_u;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
	} dest_rec_t;

	typedef struct packed {
		logic     use_rs1;
		reg_idx_t rs1;
		logic     use_rs2;
		reg_idx_t rs2;
	} src_use_t;

	typedef struct packed {
		inst_word_u inst;
		dest_rec_t  dest; // Register this instruction will write
	} issue_t;

endpackage

`default_nettype wire

// ==== hw/fetch_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_decode (
	input  logic               clk,
	input  logic               reset,
	input  logic               inst_valid,
	input  isa_pkg::inst_word_u inst,
	input  logic               stall,
	output isa_pkg::src_use_t  src,
	output logic               issue_valid,
	output isa_pkg::issue_t    issue
);

	import isa_pkg::*;

	logic       ifid_valid;
	inst_word_u ifid_inst;

	logic       use_rs;
	logic       use_rt;
	logic       wr_en;
	reg_idx_t   wr_rd;

	// The valid bit only moves when the stage is not stalled
	always_ff @(posedge clk) begin
		if (reset) begin
			ifid_valid <= 1'b0;
		end else if (!stall) begin
			ifid_valid <= inst_valid; // Issue empties IF/ID unless a new word comes in
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && inst_valid) begin
			ifid_inst <= inst;
		end
	end

	always_comb begin
		use_rs = 1'b0;
		use_rt = 1'b0;
		wr_en  = 1'b0;
		wr_rd  = ifid_inst.r_fmt.rd;
		case (ifid_inst.r_fmt.opcode)
			OP_R: begin
				case (ifid_inst.r_fmt.func)
					FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
						use_rs = 1'b1;
						use_rt = 1'b1;
						wr_en  = 1'b1;
					end
					FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
						use_rs = 1'b1; // Unary, rt is a don't care
						wr_en  = 1'b1;
					end
					FN_WWD, FN_JPR: begin
						use_rs = 1'b1;
					end
					FN_JRL: begin
						use_rs = 1'b1;
						wr_en  = 1'b1;
						wr_rd  = LINK_REG;
					end
					FN_HLT: begin
						use_rs = 1'b0; // Halt touches no register
					end
					default: begin
						use_rs = 1'b0;
					end
				endcase
			end
			OP_ADI, OP_ORI, OP_LWD: begin
				use_rs = 1'b1;
				wr_en  = 1'b1;
				wr_rd  = ifid_inst.i_fmt.rt;
			end
			OP_LHI: begin
				wr_en = 1'b1; // Loads the upper byte only, no source
				wr_rd = ifid_inst.i_fmt.rt;
			end
			OP_SWD, OP_BNE, OP_BEQ: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			OP_BGZ, OP_BLZ: begin
				use_rs = 1'b1;
			end
			OP_JAL: begin
				wr_en = 1'b1;
				wr_rd = LINK_REG;
			end
			OP_JMP: begin
				wr_en = 1'b0;
			end
			default: begin
				wr_en = 1'b0;
			end
		endcase
	end

	// An empty IF/ID needs nothing and writes nothing
	assign src.use_rs1 = ifid_valid && use_rs;
	assign src.rs1     = ifid_inst.r_fmt.rs;
	assign src.use_rs2 = ifid_valid && use_rt;
	assign src.rs2     = ifid_inst.r_fmt.rt;

	assign issue_valid     = ifid_valid && !stall;
	assign issue.inst      = ifid_inst;
	assign issue.dest.valid = ifid_valid && wr_en;
	assign issue.dest.rd   = wr_rd;

endmodule

`default_nettype wire

// ==== hw/dest_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module dest_pipe (
	input  logic              clk,
	input  logic              reset,
	input  logic              issue_valid,
	input  isa_pkg::dest_rec_t in_rec,
	output isa_pkg::dest_rec_t id_ex,
	output isa_pkg::dest_rec_t ex_mem,
	output isa_pkg::dest_rec_t mem_wb,
	output logic              retire_valid,
	output isa_pkg::reg_idx_t  retire_rd
);

	import isa_pkg::*;

	dest_rec_t stage [3];
	dest_rec_t next_rec;

	// A stalled or empty front end sends a bubble
	always_comb begin
		next_rec       = in_rec;
		next_rec.valid = issue_valid && in_rec.valid;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stage[0].valid <= 1'b0;
			stage[1].valid <= 1'b0;
			stage[2].valid <= 1'b0;
		end else begin
			stage[0].valid <= next_rec.valid;
			stage[1].valid <= stage[0].valid;
			stage[2].valid <= stage[1].valid;
		end
	end

	always_ff @(posedge clk) begin
		stage[0].rd <= next_rec.rd;
		stage[1].rd <= stage[0].rd;
		stage[2].rd <= stage[1].rd;
	end

	assign id_ex  = stage[0];
	assign ex_mem = stage[1];
	assign mem_wb = stage[2];

	assign retire_valid = stage[2].valid; // Leaves in the third cycle after issue
	assign retire_rd    = stage[2].rd;

endmodule

`default_nettype wire

// ==== hw/hazard_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_detect (
	input  isa_pkg::src_use_t  src,
	input  isa_pkg::dest_rec_t id_ex,
	input  isa_pkg::dest_rec_t ex_mem,
	input  isa_pkg::dest_rec_t mem_wb,
	output logic              stall
);

	import isa_pkg::*;

	dest_rec_t in_flight [3];

	function automatic logic reads_dest(
		input logic      use_reg,
		input reg_idx_t  idx,
		input dest_rec_t rec
	);
		return use_reg && rec.valid && (rec.rd == idx);
	endfunction

	assign in_flight[0] = id_ex;
	assign in_flight[1] = ex_mem;
	assign in_flight[2] = mem_wb; // No write-through, so MEM/WB still blocks

	always_comb begin
		stall = 1'b0;
		for (int i = 0; i < 3; i++) begin
			if (reads_dest(src.use_rs1, src.rs1, in_flight[i])) begin
				stall = 1'b1;
			end
			if (reads_dest(src.use_rs2, src.rs2, in_flight[i])) begin
				stall = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               inst_valid,
	input  isa_pkg::inst_word_u inst,
	output logic               stall,
	output logic               issue_valid,
	output isa_pkg::issue_t    issue,
	output logic               retire_valid,
	output isa_pkg::reg_idx_t  retire_rd
);

	import isa_pkg::*;

	src_use_t  src;
	dest_rec_t id_ex;
	dest_rec_t ex_mem;
	dest_rec_t mem_wb;

	fetch_decode u_fetch_decode (
		.clk         (clk),
		.reset       (reset),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.stall       (stall),
		.src         (src),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

	dest_pipe u_dest_pipe (
		.clk          (clk),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.in_rec       (issue.dest),
		.id_ex        (id_ex),
		.ex_mem       (ex_mem),
		.mem_wb       (mem_wb),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd)
	);

	hazard_detect u_hazard_detect (
		.src    (src),
		.id_ex  (id_ex),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.stall  (stall)
	);

endmodule

`default_nettype wire

// ==== dv/tb_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage;

	import isa_pkg::*;

	localparam int NUM_CYCLES  = 3000;
	localparam int DRAIN_LIMIT = 20;

	logic        clk;
	logic        reset;
	logic        inst_valid;
	inst_word_u  inst;
	logic        stall;
	logic        issue_valid;
	issue_t      issue;
	logic        retire_valid;
	reg_idx_t    retire_rd;

	logic [31:0] lcg_state = 32'hd10c_c159;
	logic        m_ifid_valid;
	logic [15:0] m_ifid_inst;
	dest_rec_t   m_pipe [3]; // ID/EX, EX/MEM and MEM/WB as the model sees them
	logic [15:0] sent_q [$];
	logic        exp_stall;
	logic        exp_issue;
	logic        exp_use_rs;
	logic        exp_use_rt;
	logic        exp_wr_en;
	reg_idx_t    exp_wr_rd;
	logic        last_accepted;
	logic        seen_accept;
	int          value_errors;
	int          other_errors;
	int          stall_run;
	int          n_accepted;
	int          n_issued;
	int          n_retired;
	int          drain_cycles;

	issue_stage dut (
		.clk          (clk),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.stall        (stall),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Category comes from the high bits, the low bits of an LCG repeat too soon
	function automatic logic [15:0] random_inst();
		logic [15:0] w;
		logic [31:0] a;
		logic [31:0] c;
		a = lcg_next();
		w = a[31:16];
		c = lcg_next();
		case (c[31:28])
			4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
				w[15:12] = OP_R;
				w[5:0]   = {3'b000, c[26:24]}; // ADD up to SHR
			end
			4'd5: begin
				w[15:12] = OP_R;
				case (c[25:24])
					2'd0: w[5:0] = FN_JPR;
					2'd1: w[5:0] = FN_JRL;
					2'd2: w[5:0] = FN_WWD;
					default: w[5:0] = FN_HLT;
				endcase
			end
			4'd6: begin
				w[15:12] = OP_R;
				w[5:0]   = 6'd8 + {2'b00, c[27:24]}; // Unused function codes
			end
			4'd7, 4'd8, 4'd9: w[15:12] = {2'b01, c[25:24]};
			4'd10: w[15:12] = OP_SWD;
			4'd11: w[15:12] = {2'b00, c[25:24]};
			4'd12: w[15:12] = c[24] ? OP_JAL : OP_JMP;
			4'd13: w[15:12] = 4'd11 + {2'b00, c[25:24]}; // Unused opcodes
			default: w = w;
		endcase
		return w;
	endfunction

	task automatic decode_needs(
		input  logic [15:0] w,
		output logic        use_rs,
		output logic        use_rt,
		output logic        wr_en,
		output reg_idx_t    wr_rd
	);
		logic [3:0] op;
		logic [5:0] fn;
		logic       alu2;
		logic       alu1;
		op     = w[15:12];
		fn     = w[5:0];
		alu2   = (op == OP_R) && (fn <= FN_ORR);
		alu1   = (op == OP_R) && (fn >= FN_NOT) && (fn <= FN_SHR);
		use_rs = alu2 || alu1 || (op inside {OP_ADI, OP_ORI, OP_LWD, OP_SWD}) ||
			(op inside {OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ}) ||
			((op == OP_R) && (fn inside {FN_WWD, FN_JPR, FN_JRL}));
		use_rt = alu2 || (op inside {OP_SWD, OP_BNE, OP_BEQ});
		wr_en  = 1'b1;
		wr_rd  = w[7:6];
		if (op inside {OP_ADI, OP_ORI, OP_LHI, OP_LWD})
			wr_rd = w[9:8];
		else if ((op == OP_JAL) || ((op == OP_R) && (fn == FN_JRL)))
			wr_rd = LINK_REG;
		else if (!(alu1 || alu2))
			wr_en = 1'b0;
	endtask

	// Jumps, LHI, HLT and every unused opcode or function code read no register
	function automatic logic reads_no_register(input logic [15:0] w);
		logic [3:0] op;
		logic [5:0] fn;
		op = w[15:12];
		fn = w[5:0];
		return (op inside {OP_JMP, OP_JAL, OP_LHI, [4'd11:4'd14]}) ||
			((op == OP_R) && (fn inside {FN_HLT, [6'd8:6'd24], 6'd27, [6'd30:6'd63]}));
	endfunction

	task automatic check_outputs;
		logic [15:0] front;
		decode_needs(m_ifid_inst, exp_use_rs, exp_use_rt, exp_wr_en, exp_wr_rd);
		exp_use_rs = exp_use_rs && m_ifid_valid;
		exp_use_rt = exp_use_rt && m_ifid_valid;
		exp_stall  = 1'b0;
		for (int i = 0; i < 3; i++) begin
			if (m_pipe[i].valid && ((exp_use_rs && (m_pipe[i].rd == m_ifid_inst[11:10])) ||
				(exp_use_rt && (m_pipe[i].rd == m_ifid_inst[9:8]))))
				exp_stall = 1'b1;
		end
		exp_issue = m_ifid_valid && !exp_stall;
		assert (stall === exp_stall) else begin
			value_errors++;
			$display("Fail stall: got %h, expected %h", stall, exp_stall);
		end
		assert (issue_valid === exp_issue) else begin
			value_errors++;
			$display("Fail issue_valid: got %h, expected %h", issue_valid, exp_issue);
		end
		if (exp_issue && sent_q.size() > 0) begin
			front = sent_q.pop_front(); // Oldest accepted word must go first
			n_issued++;
			assert (issue.inst === front) else begin
				value_errors++;
				$display("Fail issue.inst: got %h, expected %h", issue.inst, front);
			end
			assert (issue.dest.valid === exp_wr_en) else begin
				value_errors++;
				$display("Fail issue.dest.valid: got %h, expected %h",
					issue.dest.valid, exp_wr_en);
			end
			if (exp_wr_en)
				assert (issue.dest.rd === exp_wr_rd) else begin
					value_errors++;
					$display("Fail issue.dest.rd: got %h, expected %h",
						issue.dest.rd, exp_wr_rd);
				end
		end
		assert (retire_valid === m_pipe[2].valid) else begin
			value_errors++;
			$display("Fail retire_valid: got %h, expected %h", retire_valid, m_pipe[2].valid);
		end
		if (m_pipe[2].valid) begin
			n_retired++;
			assert (retire_rd === m_pipe[2].rd) else begin
				value_errors++;
				$display("Fail retire_rd: got %h, expected %h", retire_rd, m_pipe[2].rd);
			end
		end
		if (!seen_accept)
			assert (!stall && !issue_valid && !retire_valid) else begin
				other_errors++;
				$display("Outputs went active before any instruction was accepted");
			end
		stall_run = stall ? stall_run + 1 : 0;
		assert (stall_run <= 3) else begin
			other_errors++;
			$display("Stall held for more than three cycles");
		end
		assert (!(stall && m_ifid_valid && reads_no_register(m_ifid_inst))) else begin
			other_errors++;
			$display("An instruction that reads no register was stalled");
		end
	endtask

	task automatic step_model;
		last_accepted   = inst_valid && !exp_stall;
		m_pipe[2]       = m_pipe[1];
		m_pipe[1]       = m_pipe[0];
		m_pipe[0].valid = exp_issue && exp_wr_en;
		m_pipe[0].rd    = exp_wr_rd;
		if (!exp_stall)
			m_ifid_valid = inst_valid;
		if (last_accepted) begin
			m_ifid_inst = inst;
			sent_q.push_back(inst);
			n_accepted++;
			seen_accept = 1'b1;
		end
	endtask

	task automatic run_cycle(input logic allow_valid);
		logic [31:0] r;
		@(negedge clk);
		check_outputs();
		step_model();
		@(posedge clk);
		if (!inst_valid || last_accepted) begin // A refused word is held as it was
			r = lcg_next();
			inst_valid <= allow_valid && (r[31:24] < 8'd179);
			inst       <= random_inst();
		end
	endtask

	initial begin
		reset        <= 1'b1;
		inst_valid   <= 1'b0;
		inst         <= '0;
		m_ifid_valid = 1'b0;
		m_ifid_inst  = '0;
		for (int i = 0; i < 3; i++)
			m_pipe[i] = '0;
		seen_accept  = 1'b0;
		value_errors = 0;
		other_errors = 0;
		stall_run    = 0;
		n_accepted   = 0;
		n_issued     = 0;
		n_retired    = 0;
		drain_cycles = 0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
			run_cycle(cyc >= 4); // A few idle cycles first
		while ((inst_valid || m_ifid_valid || m_pipe[0].valid || m_pipe[1].valid ||
			m_pipe[2].valid) && drain_cycles < DRAIN_LIMIT) begin
			run_cycle(1'b0);
			drain_cycles++;
		end
		if (drain_cycles >= DRAIN_LIMIT) begin
			other_errors++;
			$display("Timeout while waiting for the pipeline to drain");
		end
		assert (n_accepted == n_issued) else begin
			other_errors++;
			$display("Accepted and issued instruction counts differ");
		end
		$display("Summary: %0d accepted, %0d issued, %0d retired, %0d value errors, %0d %s",
			n_accepted, n_issued, n_retired, value_errors, other_errors, "other errors");
		if (value_errors + other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hw/isa_pkg.sv
hw/fetch_decode.sv
hw/dest_pipe.sv
hw/hazard_detect.sv
hw/issue_stage.sv
dv/tb_issue_stage.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module tb_issue_stage -Mdir "$OBJ" -f build.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_issue_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
